/* common/sniffer_pkg.sv */
// Packet sniffer shared definitions
package sniffer_pkg;

  // --------------------
  // Bus widths
  // --------------------
  // AXI4-Lite control bus
  localparam int AXIL_DATA_BITS = 64;
  // 10 registers of 8 bytes
  localparam int AXIL_ADDR_BITS = 7;

  // Packet stream word
  localparam int PKT_DATA_BITS = 64;

  // --------------------
  // Host buffer fields
  // --------------------
  localparam int PID_BITS  = 6;
  localparam int DEST_BITS = 4;

  // Capture FSM states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_ARMED   = 2'd1,  // Started, waiting for host buffer
    ST_CAPTURE = 2'd2,
    ST_DONE    = 2'd3
  } sniffer_state_t;

  // Register indices, byte address is index times 8
  typedef enum logic [3:0] {
    REG_CTRL_0 = 4'd0,  // Bit 0 start
    REG_CTRL_1 = 4'd1,  // Bit 0 host buffer valid
    REG_FILTER = 4'd2,  // Mask high, pattern low
    REG_STATE  = 4'd3,  // Read only
    REG_SIZE   = 4'd4,  // Read only
    REG_TIMER  = 4'd5,  // Read only
    REG_VADDR  = 4'd6,
    REG_LEN    = 4'd7,
    REG_PID    = 4'd8,
    REG_DEST   = 4'd9
  } sniffer_reg_t;

endpackage

/* sniffer/sniffer_ctrl_slv.sv */
// Sniffer AXI4-Lite register slave
module sniffer_ctrl_slv
  import sniffer_pkg::*;
#(
  parameter int VADDR_BITS = 48,
  parameter int LEN_BITS   = 28
) (
  input  logic                        aclk,
  input  logic                        aresetn,
  // AXI4-Lite write channels
  input  logic [AXIL_ADDR_BITS-1:0]   s_axil_awaddr,
  input  logic                        s_axil_awvalid,
  output logic                        s_axil_awready,
  input  logic [AXIL_DATA_BITS-1:0]   s_axil_wdata,
  input  logic [AXIL_DATA_BITS/8-1:0] s_axil_wstrb,
  input  logic                        s_axil_wvalid,
  output logic                        s_axil_wready,
  output logic [1:0]                  s_axil_bresp,
  output logic                        s_axil_bvalid,
  input  logic                        s_axil_bready,
  // AXI4-Lite read channels
  input  logic [AXIL_ADDR_BITS-1:0]   s_axil_araddr,
  input  logic                        s_axil_arvalid,
  output logic                        s_axil_arready,
  output logic [AXIL_DATA_BITS-1:0]   s_axil_rdata,
  output logic [1:0]                  s_axil_rresp,
  output logic                        s_axil_rvalid,
  input  logic                        s_axil_rready,
  // Status from capture
  input  sniffer_state_t              state,
  input  logic [31:0]                 size,
  input  logic [63:0]                 timer,
  // Control levels
  output logic                        start,
  output logic                        host_valid,
  output logic [63:0]                 filter,
  output logic [VADDR_BITS-1:0]       host_vaddr,
  output logic [LEN_BITS-1:0]         host_len,
  output logic [PID_BITS-1:0]         host_pid,
  output logic [DEST_BITS-1:0]        host_dest
);

  // --------------------
  // Declarations
  // --------------------
  localparam int STRB_BITS = AXIL_DATA_BITS / 8;
  localparam int ADDR_LSB  = $clog2(STRB_BITS);
  localparam int IDX_BITS  = AXIL_ADDR_BITS - ADDR_LSB;
  localparam logic [1:0] RESP_OKAY = 2'b00;

  logic                      aw_en;
  logic                      wr_en;
  logic                      rd_req;
  logic [IDX_BITS-1:0]       wr_idx;
  logic [IDX_BITS-1:0]       rd_idx;
  logic [AXIL_DATA_BITS-1:0] wr_old;
  logic [AXIL_DATA_BITS-1:0] wr_new;
  logic [AXIL_DATA_BITS-1:0] rd_word;

  // Zero extended view of one register, unknown index reads zero
  function automatic logic [AXIL_DATA_BITS-1:0] reg_read(input logic [IDX_BITS-1:0] idx);
    logic [AXIL_DATA_BITS-1:0] word;
    word = '0;
    case (idx)
      REG_CTRL_0: word[0] = start;
      REG_CTRL_1: word[0] = host_valid;
      REG_FILTER: word = filter;
      REG_STATE:  word[1:0] = state;
      REG_SIZE:   word[31:0] = size;
      REG_TIMER:  word = timer;
      REG_VADDR:  word[VADDR_BITS-1:0] = host_vaddr;
      REG_LEN:    word[LEN_BITS-1:0] = host_len;
      REG_PID:    word[PID_BITS-1:0] = host_pid;
      REG_DEST:   word[DEST_BITS-1:0] = host_dest;
      default: ;
    endcase
    return word;
  endfunction

  // --------------------
  // Write channel
  // --------------------
  // Accept when both address and data present, one write in flight
  assign wr_en  = !s_axil_awready && s_axil_awvalid && s_axil_wvalid && aw_en;
  assign wr_idx = s_axil_awaddr[AXIL_ADDR_BITS-1:ADDR_LSB];
  assign s_axil_bresp = RESP_OKAY;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
      aw_en          <= 1'b1;
    end else begin
      s_axil_awready <= wr_en;
      s_axil_wready  <= wr_en;
      if (wr_en) begin
        aw_en <= 1'b0;
      end else if (s_axil_bvalid && s_axil_bready) begin
        aw_en <= 1'b1;
      end
    end
  end

  // Response one cycle after accept, held until taken
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axil_bvalid <= 1'b0;
    end else if (s_axil_awready) begin
      s_axil_bvalid <= 1'b1;
    end else if (s_axil_bready) begin
      s_axil_bvalid <= 1'b0;
    end
  end

  // Byte strobe merge with the current contents
  always_comb begin
    wr_old = reg_read(wr_idx);
    for (int i = 0; i < STRB_BITS; i++) begin
      wr_new[i*8 +: 8] = s_axil_wstrb[i] ? s_axil_wdata[i*8 +: 8] : wr_old[i*8 +: 8];
    end
  end

  // Writable registers, status indices fall to default
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      start      <= 1'b0;
      host_valid <= 1'b0;
      filter     <= '0;
      host_vaddr <= '0;
      host_len   <= '0;
      host_pid   <= '0;
      host_dest  <= '0;
    end else if (wr_en) begin
      case (wr_idx)
        REG_CTRL_0: start      <= wr_new[0];
        REG_CTRL_1: host_valid <= wr_new[0];
        REG_FILTER: filter     <= wr_new;
        REG_VADDR:  host_vaddr <= wr_new[VADDR_BITS-1:0];
        REG_LEN:    host_len   <= wr_new[LEN_BITS-1:0];
        REG_PID:    host_pid   <= wr_new[PID_BITS-1:0];
        REG_DEST:   host_dest  <= wr_new[DEST_BITS-1:0];
        default: ;
      endcase
    end
  end

  // --------------------
  // Read channel
  // --------------------
  assign rd_req = !s_axil_arready && s_axil_arvalid && !s_axil_rvalid;
  assign s_axil_rresp = RESP_OKAY;

  always_comb begin
    rd_word = reg_read(rd_idx);
  end

  // Address accept, index latched for the data phase
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axil_arready <= 1'b0;
    end else begin
      s_axil_arready <= rd_req;
    end
  end

  always_ff @(posedge aclk) begin
    if (rd_req) begin
      rd_idx <= s_axil_araddr[AXIL_ADDR_BITS-1:ADDR_LSB];
    end
    if (s_axil_arready) begin
      s_axil_rdata <= rd_word;
    end
  end

  // Data follows arready by one cycle, held until rready
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      s_axil_rvalid <= 1'b0;
    end else if (s_axil_arready) begin
      s_axil_rvalid <= 1'b1;
    end else if (s_axil_rready) begin
      s_axil_rvalid <= 1'b0;
    end
  end

endmodule

/* sniffer/sniffer_filter.sv */
// Per-packet header filter
module sniffer_filter
  import sniffer_pkg::*;
(
  input  logic                     aclk,
  input  logic                     aresetn,
  input  logic [63:0]              filter,
  // Raw packet stream
  input  logic                     pkt_valid,
  input  logic [PKT_DATA_BITS-1:0] pkt_data,
  input  logic                     pkt_last,
  // Words of passing packets
  output logic                     pass_valid,
  output logic [PKT_DATA_BITS-1:0] pass_data,
  output logic                     pass_last
);

  logic [31:0] pattern;
  logic [31:0] mask;
  logic        sof_q;   // Next word opens a packet
  logic        keep_q;  // Decision of the open packet
  logic        hit;
  logic        keep;

  // Mask in the high half, pattern in the low half
  assign pattern = filter[31:0];
  assign mask    = filter[63:32];
  assign hit     = (pkt_data[31:0] & mask) == (pattern & mask);

  // First word decides, later words reuse the held decision
  assign keep = sof_q ? hit : keep_q;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      sof_q      <= 1'b1;
      keep_q     <= 1'b0;
      pass_valid <= 1'b0;
    end else begin
      pass_valid <= pkt_valid && keep;
      if (pkt_valid) begin
        sof_q  <= pkt_last;
        keep_q <= keep;
      end
    end
  end

  // Word payload, one cycle behind the input
  always_ff @(posedge aclk) begin
    pass_data <= pkt_data;
    pass_last <= pkt_last;
  end

endmodule

/* sniffer/sniffer_capture.sv */
// Capture FSM and host write requests
module sniffer_capture
  import sniffer_pkg::*;
#(
  parameter int VADDR_BITS = 48,
  parameter int LEN_BITS   = 28
) (
  input  logic                     aclk,
  input  logic                     aresetn,
  // Control levels
  input  logic                     start,
  input  logic                     host_valid,
  input  logic [VADDR_BITS-1:0]    host_vaddr,
  input  logic [LEN_BITS-1:0]      host_len,
  input  logic [PID_BITS-1:0]      host_pid,
  input  logic [DEST_BITS-1:0]     host_dest,
  // Filtered words
  input  logic                     pass_valid,
  input  logic [PKT_DATA_BITS-1:0] pass_data,
  input  logic                     pass_last,
  // Status
  output sniffer_state_t           state,
  output logic [31:0]              size,
  output logic [63:0]              timer,
  // Host write request
  output logic                     host_wr_valid,
  output logic [VADDR_BITS-1:0]    host_wr_addr,
  output logic [PKT_DATA_BITS-1:0] host_wr_data,
  output logic [PID_BITS-1:0]      host_wr_pid,
  output logic [DEST_BITS-1:0]     host_wr_dest
);

  // --------------------
  // Buffer space check
  // --------------------
  localparam int CMP_BITS = (LEN_BITS > 32) ? LEN_BITS : 32;

  logic [CMP_BITS-1:0] size_ext;
  logic [CMP_BITS-1:0] len_ext;
  logic                room;
  logic                take;
  logic                sof_q;
  logic                sof_next;
  logic                skip_q;

  assign size_ext = CMP_BITS'(size);
  assign len_ext  = CMP_BITS'(host_len);
  assign room     = size_ext < len_ext;

  // Packet boundary tracking on the filtered stream
  assign sof_next = pass_valid ? pass_last : sof_q;

  // Word kept only while staying in capture
  assign take = (state == ST_CAPTURE) && start && room && pass_valid && !skip_q;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      sof_q <= 1'b1;
    end else begin
      sof_q <= sof_next;
    end
  end

  // --------------------
  // FSM and counters
  // --------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state  <= ST_IDLE;
      size   <= '0;
      timer  <= '0;
      skip_q <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_ARMED;
            size  <= '0;
            timer <= '0;
          end
        end
        ST_ARMED: begin
          // Tail of a packet already in flight is not captured
          if (host_valid) begin
            state  <= ST_CAPTURE;
            skip_q <= !sof_next;
          end
        end
        ST_CAPTURE: begin
          timer <= timer + 64'd1;
          if (!start || !room) begin
            state <= ST_DONE;
          end
          if (take) begin
            size <= size + 32'd8;
          end
          if (pass_valid && pass_last) begin
            skip_q <= 1'b0;
          end
        end
        ST_DONE: begin
          if (!start && !host_valid) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Request strobe
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      host_wr_valid <= 1'b0;
    end else begin
      host_wr_valid <= take;
    end
  end

  // Request payload, address from the running byte count
  always_ff @(posedge aclk) begin
    if (take) begin
      host_wr_addr <= host_vaddr + VADDR_BITS'(size);
      host_wr_data <= pass_data;
      host_wr_pid  <= host_pid;
      host_wr_dest <= host_dest;
    end
  end

endmodule

/* verilog/sniffer_top.sv */
// Packet sniffer top level
module sniffer_top
  import sniffer_pkg::*;
#(
  parameter int VADDR_BITS = 48,
  parameter int LEN_BITS   = 28
) (
  input  logic                        aclk,
  input  logic                        aresetn,
  // AXI4-Lite control slave
  input  logic [AXIL_ADDR_BITS-1:0]   s_axil_awaddr,
  input  logic                        s_axil_awvalid,
  output logic                        s_axil_awready,
  input  logic [AXIL_DATA_BITS-1:0]   s_axil_wdata,
  input  logic [AXIL_DATA_BITS/8-1:0] s_axil_wstrb,
  input  logic                        s_axil_wvalid,
  output logic                        s_axil_wready,
  output logic [1:0]                  s_axil_bresp,
  output logic                        s_axil_bvalid,
  input  logic                        s_axil_bready,
  input  logic [AXIL_ADDR_BITS-1:0]   s_axil_araddr,
  input  logic                        s_axil_arvalid,
  output logic                        s_axil_arready,
  output logic [AXIL_DATA_BITS-1:0]   s_axil_rdata,
  output logic [1:0]                  s_axil_rresp,
  output logic                        s_axil_rvalid,
  input  logic                        s_axil_rready,
  // Packet stream in
  input  logic                        pkt_valid,
  input  logic [PKT_DATA_BITS-1:0]    pkt_data,
  input  logic                        pkt_last,
  // Host write requests out
  output logic                        host_wr_valid,
  output logic [VADDR_BITS-1:0]       host_wr_addr,
  output logic [PKT_DATA_BITS-1:0]    host_wr_data,
  output logic [PID_BITS-1:0]         host_wr_pid,
  output logic [DEST_BITS-1:0]        host_wr_dest
);

  // --------------------
  // Internal wiring
  // --------------------
  // Control levels from the register file
  logic                     start;
  logic                     host_valid;
  logic [63:0]              filter;
  logic [VADDR_BITS-1:0]    host_vaddr;
  logic [LEN_BITS-1:0]      host_len;
  logic [PID_BITS-1:0]      host_pid;
  logic [DEST_BITS-1:0]     host_dest;
  // Status back to the register file
  sniffer_state_t           state;
  logic [31:0]              size;
  logic [63:0]              timer;
  // Filtered stream
  logic                     pass_valid;
  logic [PKT_DATA_BITS-1:0] pass_data;
  logic                     pass_last;

  sniffer_ctrl_slv #(
    .VADDR_BITS (VADDR_BITS),
    .LEN_BITS   (LEN_BITS)
  ) u_ctrl_slv (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .s_axil_awaddr  (s_axil_awaddr),
    .s_axil_awvalid (s_axil_awvalid),
    .s_axil_awready (s_axil_awready),
    .s_axil_wdata   (s_axil_wdata),
    .s_axil_wstrb   (s_axil_wstrb),
    .s_axil_wvalid  (s_axil_wvalid),
    .s_axil_wready  (s_axil_wready),
    .s_axil_bresp   (s_axil_bresp),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_araddr  (s_axil_araddr),
    .s_axil_arvalid (s_axil_arvalid),
    .s_axil_arready (s_axil_arready),
    .s_axil_rdata   (s_axil_rdata),
    .s_axil_rresp   (s_axil_rresp),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .state          (state),
    .size           (size),
    .timer          (timer),
    .start          (start),
    .host_valid     (host_valid),
    .filter         (filter),
    .host_vaddr     (host_vaddr),
    .host_len       (host_len),
    .host_pid       (host_pid),
    .host_dest      (host_dest)
  );

  // Header match, one cycle
  sniffer_filter u_filter (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .filter     (filter),
    .pkt_valid  (pkt_valid),
    .pkt_data   (pkt_data),
    .pkt_last   (pkt_last),
    .pass_valid (pass_valid),
    .pass_data  (pass_data),
    .pass_last  (pass_last)
  );

  // Capture and request generation, one more cycle
  sniffer_capture #(
    .VADDR_BITS (VADDR_BITS),
    .LEN_BITS   (LEN_BITS)
  ) u_capture (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .start         (start),
    .host_valid    (host_valid),
    .host_vaddr    (host_vaddr),
    .host_len      (host_len),
    .host_pid      (host_pid),
    .host_dest     (host_dest),
    .pass_valid    (pass_valid),
    .pass_data     (pass_data),
    .pass_last     (pass_last),
    .state         (state),
    .size          (size),
    .timer         (timer),
    .host_wr_valid (host_wr_valid),
    .host_wr_addr  (host_wr_addr),
    .host_wr_data  (host_wr_data),
    .host_wr_pid   (host_wr_pid),
    .host_wr_dest  (host_wr_dest)
  );

endmodule

/* sim/sniffer_assert.sv */
// Sniffer protocol assertions
module sniffer_assert
  import sniffer_pkg::*;
(
  input logic           aclk,
  input logic           aresetn,
  input logic           s_axil_bvalid,
  input logic           s_axil_bready,
  input logic           s_axil_rvalid,
  input logic           s_axil_rready,
  input logic           host_wr_valid,
  input sniffer_state_t state
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failures seen so far, read by the testbench
  int unsigned fail_count = 0;

  // --------------------
  // AXI4-Lite responses
  // --------------------
  a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
    else begin
      fail_count++;
      $error("bvalid dropped before bready");
    end

  a_rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
    else begin
      fail_count++;
      $error("rvalid dropped before rready");
    end

  // --------------------
  // Capture rules
  // --------------------
  a_wr_in_capture: assert property (@(posedge aclk) disable iff (!aresetn)
    host_wr_valid |-> state == ST_CAPTURE)
    else begin
      fail_count++;
      $error("host write request outside capture");
    end

  // Capture only ever entered from ARMED
  a_no_idle_jump: assert property (@(posedge aclk) disable iff (!aresetn)
    state == ST_IDLE |=> state != ST_CAPTURE)
    else begin
      fail_count++;
      $error("state jumped from idle to capture");
    end

endmodule

/* sim/tb_sniffer_top.sv */
// Packet sniffer testbench
module tb_sniffer_top
  import sniffer_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int VADDR_BITS = 48;
  localparam int LEN_BITS   = 28;
  localparam int NUM_TESTS  = 6;

  logic                        aclk = 1'b0;
  logic                        aresetn;
  logic [AXIL_ADDR_BITS-1:0]   s_axil_awaddr;
  logic                        s_axil_awvalid;
  logic                        s_axil_awready;
  logic [AXIL_DATA_BITS-1:0]   s_axil_wdata;
  logic [AXIL_DATA_BITS/8-1:0] s_axil_wstrb;
  logic                        s_axil_wvalid;
  logic                        s_axil_wready;
  logic [1:0]                  s_axil_bresp;
  logic                        s_axil_bvalid;
  logic                        s_axil_bready;
  logic [AXIL_ADDR_BITS-1:0]   s_axil_araddr;
  logic                        s_axil_arvalid;
  logic                        s_axil_arready;
  logic [AXIL_DATA_BITS-1:0]   s_axil_rdata;
  logic [1:0]                  s_axil_rresp;
  logic                        s_axil_rvalid;
  logic                        s_axil_rready;
  logic                        pkt_valid;
  logic [PKT_DATA_BITS-1:0]    pkt_data;
  logic                        pkt_last;
  logic                        host_wr_valid;
  logic [VADDR_BITS-1:0]       host_wr_addr;
  logic [PKT_DATA_BITS-1:0]    host_wr_data;
  logic [PID_BITS-1:0]         host_wr_pid;
  logic [DEST_BITS-1:0]        host_wr_dest;

  // --------------------
  // Scoreboard state
  // --------------------
  int seed      = 10;
  int errors    = 0;
  int checks    = 0;
  int tests_run = 0;
  int exp_room  = 0;  // Words the buffer can still take
  string cur_test = "";
  logic [63:0]              cur_filter;
  logic [VADDR_BITS-1:0]    cur_vaddr;
  logic [PID_BITS-1:0]      cur_pid;
  logic [DEST_BITS-1:0]     cur_dest;
  logic [PKT_DATA_BITS-1:0] exp_words[$];
  logic [VADDR_BITS-1:0]    got_addr[$];
  logic [PKT_DATA_BITS-1:0] got_data[$];
  logic [PID_BITS-1:0]      got_pid[$];
  logic [DEST_BITS-1:0]     got_dest[$];

  sniffer_top #(
    .VADDR_BITS (VADDR_BITS),
    .LEN_BITS   (LEN_BITS)
  ) u_dut (
    .*
  );

  bind sniffer_top sniffer_assert u_assert (
    .aclk           (aclk),
    .aresetn        (aresetn),
    .s_axil_bvalid  (s_axil_bvalid),
    .s_axil_bready  (s_axil_bready),
    .s_axil_rvalid  (s_axil_rvalid),
    .s_axil_rready  (s_axil_rready),
    .host_wr_valid  (host_wr_valid),
    .state          (state)
  );

  always #5 aclk = ~aclk;

  // Collect every host write request
  always @(posedge aclk) begin
    if (aresetn && host_wr_valid) begin
      got_addr.push_back(host_wr_addr);
      got_data.push_back(host_wr_data);
      got_pid.push_back(host_wr_pid);
      got_dest.push_back(host_wr_dest);
    end
  end

  // --------------------
  // Reference rules
  // --------------------
  function automatic logic [63:0] field_mask(input int bits);
    return (bits >= 64) ? '1 : ((64'd1 << bits) - 64'd1);
  endfunction

  // Mask in the high half, pattern in the low half
  function automatic bit header_matches(input logic [63:0] flt, input logic [63:0] word);
    return (word[31:0] & flt[63:32]) == (flt[31:0] & flt[63:32]);
  endfunction

  // --------------------
  // Compare tasks
  // --------------------
  task automatic check_data(input string name, input logic [AXIL_DATA_BITS-1:0] exp,
                            input logic [AXIL_DATA_BITS-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s %s: expected %h, actual %h", cur_test, name, exp, act);
    end
  endtask

  task automatic check_state(input string name, input sniffer_state_t exp,
                             input sniffer_state_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s %s: expected %s, actual %s", cur_test, name,
               exp.name(), act.name());
    end
  endtask

  task automatic check_wr(input string name,
                          input logic [VADDR_BITS-1:0] exp_addr,
                          input logic [PKT_DATA_BITS-1:0] exp_data,
                          input logic [VADDR_BITS-1:0] act_addr,
                          input logic [PKT_DATA_BITS-1:0] act_data);
    checks++;
    if (act_addr !== exp_addr || act_data !== exp_data) begin
      errors++;
      $display("[ERROR] %s %s: expected %h/%h, actual %h/%h",
               cur_test, name, exp_addr, exp_data, act_addr, act_data);
    end
  endtask

  // --------------------
  // Bus drivers
  // --------------------
  task automatic axil_write(input logic [3:0] idx, input logic [63:0] data,
                            input logic [7:0] strb);
    @(posedge aclk);
    s_axil_awaddr  <= {idx, 3'b000};
    s_axil_awvalid <= 1'b1;
    s_axil_wdata   <= data;
    s_axil_wstrb   <= strb;
    s_axil_wvalid  <= 1'b1;
    do @(posedge aclk); while (!s_axil_awready);
    // Data channel accepted together with the address
    check_data("wready", 64'd1, 64'(s_axil_wready));
    s_axil_awvalid <= 1'b0;
    s_axil_wvalid  <= 1'b0;
    // Response, bready held high
    do @(posedge aclk); while (!s_axil_bvalid);
    check_data("bresp", 64'd0, 64'(s_axil_bresp));
  endtask

  task automatic axil_read(input logic [3:0] idx, output logic [63:0] data);
    @(posedge aclk);
    s_axil_araddr  <= {idx, 3'b000};
    s_axil_arvalid <= 1'b1;
    do @(posedge aclk); while (!s_axil_arready);
    s_axil_arvalid <= 1'b0;
    do @(posedge aclk); while (!s_axil_rvalid);
    check_data("rresp", 64'd0, 64'(s_axil_rresp));
    data = s_axil_rdata;
  endtask

  // First word given, the rest random, kept words queued as expected
  task automatic send_packet(input int n, input logic [63:0] first);
    logic [63:0] word;
    bit keep;
    keep = header_matches(cur_filter, first);
    for (int i = 0; i < n; i++) begin
      word = (i == 0) ? first : {$random(seed), $random(seed)};
      if (keep && exp_room > 0) begin
        exp_words.push_back(word);
        exp_room--;
      end
      @(posedge aclk);
      pkt_valid <= 1'b1;
      pkt_data  <= word;
      pkt_last  <= (i == n - 1);
    end
    @(posedge aclk);
    pkt_valid <= 1'b0;
    pkt_last  <= 1'b0;
    // Two cycle pipeline plus monitor sample
    repeat (4) @(posedge aclk);
  endtask

  // Host buffer setup, mirrored into the reference copy
  task automatic program_buffer(input logic [63:0] vaddr, input logic [63:0] len,
                                input logic [63:0] pid, input logic [63:0] dest);
    axil_write(REG_VADDR, vaddr, 8'hff);
    axil_write(REG_LEN, len, 8'hff);
    axil_write(REG_PID, pid, 8'hff);
    axil_write(REG_DEST, dest, 8'hff);
    cur_vaddr = vaddr[VADDR_BITS-1:0];
    cur_pid   = pid[PID_BITS-1:0];
    cur_dest  = dest[DEST_BITS-1:0];
    exp_room  = int'(len & field_mask(LEN_BITS)) / 8;
  endtask

  task automatic clear_captures();
    exp_words.delete();
    got_addr.delete();
    got_data.delete();
    got_pid.delete();
    got_dest.delete();
  endtask

  task automatic compare_captures(input string name);
    check_data({name, " count"}, 64'(exp_words.size()), 64'(got_data.size()));
    if (got_data.size() == exp_words.size()) begin
      for (int k = 0; k < exp_words.size(); k++) begin
        check_wr(name, cur_vaddr + VADDR_BITS'(8 * k), exp_words[k], got_addr[k], got_data[k]);
        check_data({name, " pid"}, 64'(cur_pid), 64'(got_pid[k]));
        check_data({name, " dest"}, 64'(cur_dest), 64'(got_dest[k]));
      end
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("PASS  %s", name);
    end else begin
      $display("FAIL  %s (%0d errors)", name, errors - err_start);
    end
  endtask

  // --------------------
  // Tests
  // --------------------
  task automatic register_round_trip();
    int err_start;
    logic [63:0] rd;
    err_start = errors;
    cur_test  = "register round trip";
    axil_write(REG_FILTER, 64'h0123_4567_89ab_cdef, 8'hff);
    axil_read(REG_FILTER, rd);
    check_data("filter full", 64'h0123_4567_89ab_cdef, rd);
    // Low four bytes only
    axil_write(REG_FILTER, 64'h5555_5555_5555_5555, 8'h0f);
    axil_read(REG_FILTER, rd);
    check_data("filter partial", 64'h0123_4567_5555_5555, rd);
    axil_write(REG_VADDR, 64'hffff_1234_5678_9abc, 8'hff);
    axil_read(REG_VADDR, rd);
    check_data("vaddr", 64'hffff_1234_5678_9abc & field_mask(VADDR_BITS), rd);
    axil_write(REG_LEN, '1, 8'hff);
    axil_read(REG_LEN, rd);
    check_data("len", field_mask(LEN_BITS), rd);
    axil_write(REG_PID, 64'hff, 8'hff);
    axil_read(REG_PID, rd);
    check_data("pid", 64'hff & field_mask(PID_BITS), rd);
    axil_write(REG_DEST, 64'hff, 8'hff);
    axil_read(REG_DEST, rd);
    check_data("dest", 64'hff & field_mask(DEST_BITS), rd);
    axil_write(REG_CTRL_0, 64'hffff_fffe, 8'hff);
    axil_read(REG_CTRL_0, rd);
    check_data("ctrl_0", 64'h0, rd);
    axil_write(REG_CTRL_1, '1, 8'hff);
    axil_read(REG_CTRL_1, rd);
    check_data("ctrl_1 set", 64'h1, rd);
    axil_write(REG_CTRL_1, 64'h0, 8'hff);
    axil_read(REG_CTRL_1, rd);
    check_data("ctrl_1 clear", 64'h0, rd);
    axil_read(4'd12, rd);
    check_data("index 12", 64'h0, rd);
    // Status register is read only
    axil_write(REG_SIZE, 64'hdead_beef, 8'hff);
    axil_read(REG_SIZE, rd);
    check_data("size write", 64'h0, rd);
    report_test("register round trip", err_start);
  endtask

  task automatic state_sequence();
    int err_start;
    logic [63:0] rd;
    err_start = errors;
    cur_test  = "state sequence";
    axil_write(REG_CTRL_0, 64'h1, 8'hff);
    axil_read(REG_STATE, rd);
    check_state("after start", ST_ARMED, sniffer_state_t'(rd[1:0]));
    axil_write(REG_CTRL_1, 64'h1, 8'hff);
    axil_read(REG_STATE, rd);
    check_state("after host valid", ST_CAPTURE, sniffer_state_t'(rd[1:0]));
    axil_write(REG_CTRL_0, 64'h0, 8'hff);
    axil_read(REG_STATE, rd);
    check_state("after stop", ST_DONE, sniffer_state_t'(rd[1:0]));
    axil_write(REG_CTRL_1, 64'h0, 8'hff);
    axil_read(REG_STATE, rd);
    check_state("after release", ST_IDLE, sniffer_state_t'(rd[1:0]));
    report_test("state sequence", err_start);
  endtask

  task automatic filter_select();
    int err_start;
    err_start = errors;
    cur_test  = "filter";
    clear_captures();
    program_buffer(64'h0000_0012_3400_0000, 64'd1024, 64'd5, 64'd3);
    // Upper 16 bits of the header must be cafe
    cur_filter = {32'hffff_0000, 32'hcafe_0000};
    axil_write(REG_FILTER, cur_filter, 8'hff);
    axil_write(REG_CTRL_0, 64'h1, 8'hff);
    axil_write(REG_CTRL_1, 64'h1, 8'hff);
    send_packet(3, 64'h1111_2222_cafe_1234);
    send_packet(2, 64'h0000_0000_beef_0000);
    send_packet(2, 64'h3333_4444_cafe_9999);
    compare_captures("filter");
    report_test("filter", err_start);
  endtask

  task automatic write_requests();
    int err_start;
    logic [63:0] rd;
    err_start = errors;
    cur_test  = "write requests";
    send_packet(4, 64'h5555_6666_cafe_0001);
    compare_captures("write requests");
    axil_read(REG_SIZE, rd);
    check_data("captured size", 64'(8 * exp_words.size()), rd);
    axil_write(REG_CTRL_0, 64'h0, 8'hff);
    axil_write(REG_CTRL_1, 64'h0, 8'hff);
    report_test("write requests", err_start);
  endtask

  task automatic length_limit();
    int err_start;
    logic [63:0] rd;
    err_start = errors;
    cur_test  = "length limit";
    clear_captures();
    program_buffer(64'h0000_0000_0008_0000, 64'd24, 64'd9, 64'd7);
    axil_write(REG_CTRL_0, 64'h1, 8'hff);
    axil_write(REG_CTRL_1, 64'h1, 8'hff);
    send_packet(5, 64'h0000_0000_cafe_abcd);
    check_data("limit count", 64'd3, 64'(got_data.size()));
    compare_captures("length limit");
    axil_read(REG_STATE, rd);
    check_state("limit state", ST_DONE, sniffer_state_t'(rd[1:0]));
    axil_read(REG_SIZE, rd);
    check_data("limit size", 64'd24, rd);
    report_test("length limit", err_start);
  endtask

  // Runs in ST_DONE left by the length test
  task automatic timer_hold();
    int err_start;
    logic [63:0] t_first;
    logic [63:0] t_second;
    logic [63:0] rd;
    err_start = errors;
    cur_test  = "timer";
    axil_read(REG_TIMER, t_first);
    checks++;
    if (t_first == 64'd0) begin
      errors++;
      $display("[ERROR] %s: timer still zero after a capture", cur_test);
    end
    repeat (10) @(posedge aclk);
    axil_read(REG_TIMER, t_second);
    check_data("timer frozen", t_first, t_second);
    axil_write(REG_CTRL_0, 64'h0, 8'hff);
    axil_write(REG_CTRL_1, 64'h0, 8'hff);
    axil_read(REG_STATE, rd);
    check_state("back to idle", ST_IDLE, sniffer_state_t'(rd[1:0]));
    report_test("timer", err_start);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    aresetn        <= 1'b0;
    s_axil_awaddr  <= '0;
    s_axil_awvalid <= 1'b0;
    s_axil_wdata   <= '0;
    s_axil_wstrb   <= '0;
    s_axil_wvalid  <= 1'b0;
    s_axil_bready  <= 1'b1;
    s_axil_araddr  <= '0;
    s_axil_arvalid <= 1'b0;
    s_axil_rready  <= 1'b1;
    pkt_valid      <= 1'b0;
    pkt_data       <= '0;
    pkt_last       <= 1'b0;
    cur_filter      = '0;
    repeat (4) @(posedge aclk);
    aresetn <= 1'b1;
    register_round_trip();
    state_sequence();
    filter_select();
    write_requests();
    length_limit();
    timer_hold();
    $display("Tests run %0d, checks %0d, errors %0d, assertion failures %0d",
             tests_run, checks, errors, u_dut.u_assert.fail_count);
    if (errors == 0 && u_dut.u_assert.fail_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Watchdog, 2 us per test
  initial begin
    #(NUM_TESTS * 2000);
    $display("Watchdog expired, the DUT stopped responding");
    $display("Test failures found");
    $finish;
  end

endmodule

/* flist.f */
common/sniffer_pkg.sv
sniffer/sniffer_ctrl_slv.sv
sniffer/sniffer_filter.sv
sniffer/sniffer_capture.sv
verilog/sniffer_top.sv
sim/sniffer_assert.sv
sim/tb_sniffer_top.sv

/* Bender.yml */
package:
  name: sniffer

sources:
  - common/sniffer_pkg.sv
  - sniffer/sniffer_ctrl_slv.sv
  - sniffer/sniffer_filter.sv
  - sniffer/sniffer_capture.sv
  - verilog/sniffer_top.sv
  - target: test
    files:
      - sim/sniffer_assert.sv
      - sim/tb_sniffer_top.sv
